/* verilog/axis_route_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared types for the stream router
// output port enum, demux frame state, destination id
// ~~~~~~~~~~~~~~~~~~~~

package axis_route_pkg;

    // output port picked for a frame
    typedef enum logic [1:0] {
        PORT_0 = 2'd0,
        PORT_1 = 2'd1,
        PORT_2 = 2'd2,
        PORT_3 = 2'd3
    } route_port_e;

    // demux frame tracking
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_e;

    typedef logic [7:0] dest_id_t;

endpackage

/* verilog/route_select.sv */
// ~~~~~~~~~~~~~~~~~~~~
// four-entry route table
// maps the head-beat destination id to an output port
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module route_select #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cfg_wr,
    input  logic [1:0]                   cfg_index,
    input  axis_route_pkg::dest_id_t     cfg_dest_id,
    input  logic [DATA_WIDTH-1:0]        s_tdata,
    output axis_route_pkg::route_port_e  route_port
);

    localparam int ID_WIDTH = $bits(axis_route_pkg::dest_id_t);

    axis_route_pkg::dest_id_t entry_id [4];
    logic [3:0]               entry_valid;
    axis_route_pkg::dest_id_t head_id;
    logic [3:0]               hit;

    // destination id sits in the top byte of the first beat
    assign head_id = s_tdata[DATA_WIDTH-1 -: ID_WIDTH];

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            entry_id[cfg_index] <= cfg_dest_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= 4'b0000;
        end else if (cfg_wr) begin
            entry_valid[cfg_index] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hit[i] = entry_valid[i] && (entry_id[i] == head_id);
        end
    end

    // lowest matching entry wins, no match falls through to port 3
    always_comb begin
        if (hit[0]) begin
            route_port = axis_route_pkg::PORT_0;
        end else if (hit[1]) begin
            route_port = axis_route_pkg::PORT_1;
        end else if (hit[2]) begin
            route_port = axis_route_pkg::PORT_2;
        end else begin
            route_port = axis_route_pkg::PORT_3;
        end
    end

endmodule

/* verilog/port_frame_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// saturating frame counter for one output stream
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module port_frame_counter #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tvalid,
    input  logic                   tready,
    input  logic                   tlast,
    output logic [COUNT_WIDTH-1:0] frame_count
);

    logic [COUNT_WIDTH-1:0] count_reg;
    logic                   frame_done;
    logic                   saturated;

    // a frame completes when its last beat transfers
    assign frame_done = tvalid && tready && tlast;
    assign saturated  = &count_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_reg <= '0;
        end else if (frame_done && !saturated) begin
            count_reg <= count_reg + 1'b1;
        end
    end

    assign frame_count = count_reg;

endmodule

/* verilog/axis_demux_64_4.sv */
// ~~~~~~~~~~~~~~~~~~~~
// four-port 64-bit stream demultiplexer
// frame-based port select, registered output stage with skid register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axis_demux_64_4 #(
    parameter int DATA_WIDTH = 64,
    parameter int KEEP_WIDTH = DATA_WIDTH / 8
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [DATA_WIDTH-1:0]        s_tdata,
    input  logic [KEEP_WIDTH-1:0]        s_tkeep,
    input  logic                         s_tvalid,
    output logic                         s_tready,
    input  logic                         s_tlast,
    input  logic                         s_tuser,

    output logic [DATA_WIDTH-1:0]        m0_tdata,
    output logic [KEEP_WIDTH-1:0]        m0_tkeep,
    output logic                         m0_tvalid,
    input  logic                         m0_tready,
    output logic                         m0_tlast,
    output logic                         m0_tuser,

    output logic [DATA_WIDTH-1:0]        m1_tdata,
    output logic [KEEP_WIDTH-1:0]        m1_tkeep,
    output logic                         m1_tvalid,
    input  logic                         m1_tready,
    output logic                         m1_tlast,
    output logic                         m1_tuser,

    output logic [DATA_WIDTH-1:0]        m2_tdata,
    output logic [KEEP_WIDTH-1:0]        m2_tkeep,
    output logic                         m2_tvalid,
    input  logic                         m2_tready,
    output logic                         m2_tlast,
    output logic                         m2_tuser,

    output logic [DATA_WIDTH-1:0]        m3_tdata,
    output logic [KEEP_WIDTH-1:0]        m3_tkeep,
    output logic                         m3_tvalid,
    input  logic                         m3_tready,
    output logic                         m3_tlast,
    output logic                         m3_tuser,

    input  logic                         enable,
    input  axis_route_pkg::route_port_e  route_port
);

    axis_route_pkg::route_port_e  select_reg;
    axis_route_pkg::route_port_e  select_next;
    axis_route_pkg::frame_state_e frame_reg;
    axis_route_pkg::frame_state_e frame_next;
    logic                         s_tready_reg;
    logic                         s_tready_next;

    logic [3:0]            m_tready_vec;
    logic [3:0]            m_tvalid_reg;
    logic [3:0]            m_tvalid_next;
    logic [3:0]            port_onehot;
    logic                  cur_tready;
    logic                  cur_tvalid;

    // beat accepted from the input this cycle
    logic                  int_tvalid;
    logic                  int_tready_reg;
    logic                  int_tready_early;

    logic [DATA_WIDTH-1:0] out_tdata_reg;
    logic [KEEP_WIDTH-1:0] out_tkeep_reg;
    logic                  out_tlast_reg;
    logic                  out_tuser_reg;

    logic [DATA_WIDTH-1:0] tmp_tdata_reg;
    logic [KEEP_WIDTH-1:0] tmp_tkeep_reg;
    logic                  tmp_tlast_reg;
    logic                  tmp_tuser_reg;
    logic                  tmp_tvalid_reg;
    logic                  tmp_tvalid_next;

    logic                  store_int_to_out;
    logic                  store_int_to_tmp;
    logic                  store_tmp_to_out;

    assign s_tready     = s_tready_reg;
    assign m_tready_vec = {m3_tready, m2_tready, m1_tready, m0_tready};
    assign port_onehot  = 4'b0001 << select_reg;
    assign cur_tready   = m_tready_vec[select_reg];
    assign cur_tvalid   = m_tvalid_reg[select_reg];
    assign int_tvalid   = s_tvalid && s_tready_reg;

    // keep accepting if the output drains, or the skid register stays free
    assign int_tready_early = cur_tready || (!tmp_tvalid_reg && (!cur_tvalid || !int_tvalid));

    // frame tracking latches the port only at a frame head
    always_comb begin
        select_next = select_reg;
        frame_next  = frame_reg;
        if (frame_reg == axis_route_pkg::FRAME_ACTIVE) begin
            if (int_tvalid && s_tlast) begin
                frame_next = axis_route_pkg::FRAME_IDLE;
            end
        end else if (enable && s_tvalid && !cur_tvalid) begin
            frame_next  = axis_route_pkg::FRAME_ACTIVE;
            select_next = route_port;
        end
        s_tready_next = int_tready_early && (frame_next == axis_route_pkg::FRAME_ACTIVE);
    end

    always_comb begin
        m_tvalid_next    = m_tvalid_reg;
        tmp_tvalid_next  = tmp_tvalid_reg;
        store_int_to_out = 1'b0;
        store_int_to_tmp = 1'b0;
        store_tmp_to_out = 1'b0;
        if (int_tready_reg) begin
            if (cur_tready || !cur_tvalid) begin
                m_tvalid_next    = int_tvalid ? port_onehot : 4'b0000;
                store_int_to_out = 1'b1;
            end else begin
                // park the beat while the output is stalled
                tmp_tvalid_next  = int_tvalid;
                store_int_to_tmp = 1'b1;
            end
        end else if (cur_tready) begin
            m_tvalid_next    = tmp_tvalid_reg ? port_onehot : 4'b0000;
            tmp_tvalid_next  = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            select_reg     <= axis_route_pkg::PORT_0;
            frame_reg      <= axis_route_pkg::FRAME_IDLE;
            s_tready_reg   <= 1'b0;
            m_tvalid_reg   <= 4'b0000;
            int_tready_reg <= 1'b0;
            tmp_tvalid_reg <= 1'b0;
        end else begin
            select_reg     <= select_next;
            frame_reg      <= frame_next;
            s_tready_reg   <= s_tready_next;
            m_tvalid_reg   <= m_tvalid_next;
            int_tready_reg <= int_tready_early;
            tmp_tvalid_reg <= tmp_tvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_tdata_reg <= s_tdata;
            out_tkeep_reg <= s_tkeep;
            out_tlast_reg <= s_tlast;
            out_tuser_reg <= s_tuser;
        end else if (store_tmp_to_out) begin
            out_tdata_reg <= tmp_tdata_reg;
            out_tkeep_reg <= tmp_tkeep_reg;
            out_tlast_reg <= tmp_tlast_reg;
            out_tuser_reg <= tmp_tuser_reg;
        end
        if (store_int_to_tmp) begin
            tmp_tdata_reg <= s_tdata;
            tmp_tkeep_reg <= s_tkeep;
            tmp_tlast_reg <= s_tlast;
            tmp_tuser_reg <= s_tuser;
        end
    end

    // payload is shared, only tvalid differs per port
    assign m0_tdata  = out_tdata_reg;
    assign m0_tkeep  = out_tkeep_reg;
    assign m0_tvalid = m_tvalid_reg[0];
    assign m0_tlast  = out_tlast_reg;
    assign m0_tuser  = out_tuser_reg;
    assign m1_tdata  = out_tdata_reg;
    assign m1_tkeep  = out_tkeep_reg;
    assign m1_tvalid = m_tvalid_reg[1];
    assign m1_tlast  = out_tlast_reg;
    assign m1_tuser  = out_tuser_reg;
    assign m2_tdata  = out_tdata_reg;
    assign m2_tkeep  = out_tkeep_reg;
    assign m2_tvalid = m_tvalid_reg[2];
    assign m2_tlast  = out_tlast_reg;
    assign m2_tuser  = out_tuser_reg;
    assign m3_tdata  = out_tdata_reg;
    assign m3_tkeep  = out_tkeep_reg;
    assign m3_tvalid = m_tvalid_reg[3];
    assign m3_tlast  = out_tlast_reg;
    assign m3_tuser  = out_tuser_reg;

endmodule

/* verilog/axis_router_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// 64-bit stream frame router top level
// route table, demux and per-port frame counters
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axis_router_top #(
    parameter int DATA_WIDTH  = 64,
    parameter int KEEP_WIDTH  = DATA_WIDTH / 8,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [DATA_WIDTH-1:0]    s_tdata,
    input  logic [KEEP_WIDTH-1:0]    s_tkeep,
    input  logic                     s_tvalid,
    output logic                     s_tready,
    input  logic                     s_tlast,
    input  logic                     s_tuser,

    output logic [DATA_WIDTH-1:0]    m0_tdata,
    output logic [KEEP_WIDTH-1:0]    m0_tkeep,
    output logic                     m0_tvalid,
    input  logic                     m0_tready,
    output logic                     m0_tlast,
    output logic                     m0_tuser,

    output logic [DATA_WIDTH-1:0]    m1_tdata,
    output logic [KEEP_WIDTH-1:0]    m1_tkeep,
    output logic                     m1_tvalid,
    input  logic                     m1_tready,
    output logic                     m1_tlast,
    output logic                     m1_tuser,

    output logic [DATA_WIDTH-1:0]    m2_tdata,
    output logic [KEEP_WIDTH-1:0]    m2_tkeep,
    output logic                     m2_tvalid,
    input  logic                     m2_tready,
    output logic                     m2_tlast,
    output logic                     m2_tuser,

    output logic [DATA_WIDTH-1:0]    m3_tdata,
    output logic [KEEP_WIDTH-1:0]    m3_tkeep,
    output logic                     m3_tvalid,
    input  logic                     m3_tready,
    output logic                     m3_tlast,
    output logic                     m3_tuser,

    input  logic                     cfg_wr,
    input  logic [1:0]               cfg_index,
    input  axis_route_pkg::dest_id_t cfg_dest_id,
    input  logic                     enable,

    output logic [COUNT_WIDTH-1:0]   frame_count_0,
    output logic [COUNT_WIDTH-1:0]   frame_count_1,
    output logic [COUNT_WIDTH-1:0]   frame_count_2,
    output logic [COUNT_WIDTH-1:0]   frame_count_3
);

    axis_route_pkg::route_port_e route_port;

    route_select #(
        .DATA_WIDTH(DATA_WIDTH)
    ) route_select_inst (.*);

    // stream and control ports share names with the top level
    axis_demux_64_4 #(
        .DATA_WIDTH(DATA_WIDTH),
        .KEEP_WIDTH(KEEP_WIDTH)
    ) axis_demux_inst (.*);

    port_frame_counter #(.COUNT_WIDTH(COUNT_WIDTH)) frame_counter_0_inst (
        .clk(clk), .rst(rst),
        .tvalid(m0_tvalid), .tready(m0_tready), .tlast(m0_tlast),
        .frame_count(frame_count_0)
    );

    port_frame_counter #(.COUNT_WIDTH(COUNT_WIDTH)) frame_counter_1_inst (
        .clk(clk), .rst(rst),
        .tvalid(m1_tvalid), .tready(m1_tready), .tlast(m1_tlast),
        .frame_count(frame_count_1)
    );

    port_frame_counter #(.COUNT_WIDTH(COUNT_WIDTH)) frame_counter_2_inst (
        .clk(clk), .rst(rst),
        .tvalid(m2_tvalid), .tready(m2_tready), .tlast(m2_tlast),
        .frame_count(frame_count_2)
    );

    port_frame_counter #(.COUNT_WIDTH(COUNT_WIDTH)) frame_counter_3_inst (
        .clk(clk), .rst(rst),
        .tvalid(m3_tvalid), .tready(m3_tready), .tlast(m3_tlast),
        .frame_count(frame_count_3)
    );

endmodule

/* testbench/tb_router_checks.svh */
// ~~~~~~~~~~~~~~~~~~~~
// testbench helpers for the stream router
// lcg, reference routing function, compare tasks
// ~~~~~~~~~~~~~~~~~~~~

`ifndef TB_ROUTER_CHECKS_SVH
`define TB_ROUTER_CHECKS_SVH

// one lcg step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected port from the testbench copy of the route table
function automatic axis_route_pkg::route_port_e route_of(
    input axis_route_pkg::dest_id_t id
);
    axis_route_pkg::route_port_e port;
    port = axis_route_pkg::PORT_3;
    // scan downward so the lowest matching entry is written last
    for (int i = 3; i >= 0; i--) begin
        if (ref_valid[i] && ref_id[i] == id) begin
            port = axis_route_pkg::route_port_e'(i[1:0]);
        end
    end
    return port;
endfunction

// beat is packed as {last, user, keep, data}
task automatic check_beat(input string name, input axis_route_pkg::route_port_e port,
                          input logic [BEAT_WIDTH-1:0] expected,
                          input logic [DATA_WIDTH-1:0] data, input logic [KEEP_WIDTH-1:0] keep,
                          input logic last, input logic user);
    logic [BEAT_WIDTH-1:0] actual;
    actual = {last, user, keep, data};
    if (actual !== expected) begin
        mismatch_count++;
        $display("MISMATCH %s port %0d expected %h actual %h", name, port, expected, actual);
    end
endtask

task automatic check_count(input string name, input int port,
                           input logic [COUNT_WIDTH-1:0] expected,
                           input logic [COUNT_WIDTH-1:0] actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("MISMATCH %s port %0d expected %0d actual %0d", name, port, expected, actual);
    end
endtask

`endif

/* testbench/tb_axis_router.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the stream frame router
// clock, reset, frame stimulus, per-port scoreboards, closing report
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_axis_router;

    localparam int DATA_WIDTH  = 64;
    localparam int KEEP_WIDTH  = DATA_WIDTH / 8;
    localparam int COUNT_WIDTH = 16;
    localparam int BEAT_WIDTH  = DATA_WIDTH + KEEP_WIDTH + 2;
    localparam int TIMEOUT     = 200;

    logic                     clk;
    logic                     rst;
    logic [DATA_WIDTH-1:0]    s_tdata;
    logic [KEEP_WIDTH-1:0]    s_tkeep;
    logic                     s_tvalid, s_tready, s_tlast, s_tuser;
    logic [DATA_WIDTH-1:0]    m0_tdata, m1_tdata, m2_tdata, m3_tdata;
    logic [KEEP_WIDTH-1:0]    m0_tkeep, m1_tkeep, m2_tkeep, m3_tkeep;
    logic                     m0_tvalid, m1_tvalid, m2_tvalid, m3_tvalid;
    logic                     m0_tready, m1_tready, m2_tready, m3_tready;
    logic                     m0_tlast, m1_tlast, m2_tlast, m3_tlast;
    logic                     m0_tuser, m1_tuser, m2_tuser, m3_tuser;
    logic                     cfg_wr;
    logic [1:0]               cfg_index;
    axis_route_pkg::dest_id_t cfg_dest_id;
    logic                     enable;
    logic [COUNT_WIDTH-1:0]   frame_count_0, frame_count_1, frame_count_2, frame_count_3;

    // testbench copy of the route table and the per-port scoreboards
    axis_route_pkg::dest_id_t ref_id [4];
    logic [3:0]               ref_valid;
    logic [BEAT_WIDTH-1:0]    exp_q0 [$], exp_q1 [$], exp_q2 [$], exp_q3 [$];
    logic [COUNT_WIDTH-1:0]   exp_frames [4];
    logic [31:0]              stim_seed;
    logic [31:0]              ready_seed;
    logic                     ready_random;
    logic                     stalled;
    int                       mismatch_count, protocol_count, timeout_count;
    string                    test_name;

    `include "tb_router_checks.svh"

    axis_router_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .KEEP_WIDTH(KEEP_WIDTH),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) axis_router_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // output back-pressure with ready about three cycles in four when random
    initial begin
        ready_seed = 32'h39ef;
        {m3_tready, m2_tready, m1_tready, m0_tready} = 4'b1111;
        forever begin
            @(negedge clk);
            ready_seed = lcg_next(ready_seed);
            if (ready_random) begin
                {m3_tready, m2_tready, m1_tready, m0_tready} =
                    ready_seed[19:16] | ready_seed[23:20];
            end else begin
                {m3_tready, m2_tready, m1_tready, m0_tready} = 4'b1111;
            end
        end
    end

    function automatic int pending_beats();
        return exp_q0.size() + exp_q1.size() + exp_q2.size() + exp_q3.size();
    endfunction

    task automatic push_beat(input axis_route_pkg::route_port_e port,
                             input logic [BEAT_WIDTH-1:0] beat);
        case (port)
            axis_route_pkg::PORT_0: exp_q0.push_back(beat);
            axis_route_pkg::PORT_1: exp_q1.push_back(beat);
            axis_route_pkg::PORT_2: exp_q2.push_back(beat);
            axis_route_pkg::PORT_3: exp_q3.push_back(beat);
        endcase
    endtask

    task automatic take_beat(input axis_route_pkg::route_port_e port,
                             input logic [DATA_WIDTH-1:0] data, input logic [KEEP_WIDTH-1:0] keep,
                             input logic last, input logic user);
        logic [BEAT_WIDTH-1:0] expected;
        int                    depth;
        case (port)
            axis_route_pkg::PORT_0: depth = exp_q0.size();
            axis_route_pkg::PORT_1: depth = exp_q1.size();
            axis_route_pkg::PORT_2: depth = exp_q2.size();
            axis_route_pkg::PORT_3: depth = exp_q3.size();
        endcase
        if (depth == 0) begin
            protocol_count++;
            $display("port %0d delivered a beat that no frame was routed to", port);
        end else begin
            case (port)
                axis_route_pkg::PORT_0: expected = exp_q0.pop_front();
                axis_route_pkg::PORT_1: expected = exp_q1.pop_front();
                axis_route_pkg::PORT_2: expected = exp_q2.pop_front();
                axis_route_pkg::PORT_3: expected = exp_q3.pop_front();
            endcase
            check_beat(test_name, port, expected, data, keep, last, user);
        end
    endtask

    // monitor checks every output transfer against its port's queue
    always @(posedge clk) begin
        if (!rst) begin
            if ($countones({m3_tvalid, m2_tvalid, m1_tvalid, m0_tvalid}) > 1) begin
                protocol_count++;
                $display("more than one output tvalid is high at %0t", $time);
            end
            if (m0_tvalid && m0_tready) begin
                take_beat(axis_route_pkg::PORT_0, m0_tdata, m0_tkeep, m0_tlast, m0_tuser);
            end
            if (m1_tvalid && m1_tready) begin
                take_beat(axis_route_pkg::PORT_1, m1_tdata, m1_tkeep, m1_tlast, m1_tuser);
            end
            if (m2_tvalid && m2_tready) begin
                take_beat(axis_route_pkg::PORT_2, m2_tdata, m2_tkeep, m2_tlast, m2_tuser);
            end
            if (m3_tvalid && m3_tready) begin
                take_beat(axis_route_pkg::PORT_3, m3_tdata, m3_tkeep, m3_tlast, m3_tuser);
            end
        end
    end

    task cfg_write(input logic [1:0] index, input axis_route_pkg::dest_id_t id);
        cfg_wr      = 1'b1;
        cfg_index   = index;
        cfg_dest_id = id;
        @(negedge clk);
        cfg_wr           = 1'b0;
        ref_id[index]    = id;
        ref_valid[index] = 1'b1;
    endtask

    // starts on a falling edge and holds enable low at the head for hold cycles
    task send_frame(input axis_route_pkg::dest_id_t id, input int len, input int hold);
        axis_route_pkg::route_port_e port;
        logic [DATA_WIDTH-1:0]       data;
        logic [KEEP_WIDTH-1:0]       keep;
        logic                        user;
        logic                        last;
        int                          cnt;
        port = route_of(id);
        exp_frames[port] = exp_frames[port] + COUNT_WIDTH'(1);
        for (int b = 0; b < len && !stalled; b++) begin
            stim_seed  = lcg_next(stim_seed);
            data[63:32] = stim_seed;
            stim_seed  = lcg_next(stim_seed);
            data[31:0] = stim_seed;
            stim_seed  = lcg_next(stim_seed);
            keep = stim_seed[23:16];
            user = stim_seed[27];
            last = (b == len - 1);
            if (b == 0) begin
                data[DATA_WIDTH-1 -: 8] = id;
            end
            push_beat(port, {last, user, keep, data});
            s_tdata  = data;
            s_tkeep  = keep;
            s_tuser  = user;
            s_tlast  = last;
            s_tvalid = 1'b1;
            if (b == 0 && hold > 0) begin
                enable = 1'b0;
                for (int i = 0; i < hold; i++) begin
                    @(negedge clk);
                    if (s_tready !== 1'b0) begin
                        protocol_count++;
                        $display("s_tready went high while enable was low");
                    end
                end
                enable = 1'b1;
            end
            cnt = 0;
            while (!s_tready && !stalled) begin
                @(negedge clk);
                cnt++;
                if (cnt >= TIMEOUT) begin
                    timeout_count++;
                    stalled = 1'b1;
                    $display("timeout: s_tready stayed low for %0d cycles in %s", cnt, test_name);
                end
            end
            @(negedge clk);
        end
        s_tvalid = 1'b0;
    endtask

    task send_random_frames(input int count, input logic table_only);
        axis_route_pkg::dest_id_t id;
        int                       len;
        for (int f = 0; f < count && !stalled; f++) begin
            stim_seed = lcg_next(stim_seed);
            len = 1 + int'(stim_seed[18:16]) % 6;
            if (table_only || stim_seed[22:20] < 3'd4) begin
                id = ref_id[stim_seed[21:20]];
            end else if (stim_seed[22:20] == 3'd4) begin
                id = 8'hee;
            end else begin
                id = stim_seed[31:24];
            end
            send_frame(id, len, 0);
        end
    endtask

    task drain_outputs();
        int cnt;
        cnt = 0;
        while (pending_beats() != 0 && !stalled) begin
            @(negedge clk);
            cnt++;
            if (cnt >= TIMEOUT) begin
                timeout_count++;
                stalled = 1'b1;
                $display("timeout: %0d beats never left the outputs in %s", pending_beats(),
                         test_name);
            end
        end
        @(negedge clk);
    endtask

    initial begin
        rst          = 1'b1;
        s_tdata      = '0;
        s_tkeep      = '0;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        s_tuser      = 1'b0;
        cfg_wr       = 1'b0;
        cfg_index    = 2'd0;
        cfg_dest_id  = '0;
        enable       = 1'b1;
        ref_valid    = 4'b0000;
        stim_seed    = 32'h39ef;
        ready_random = 1'b0;
        stalled      = 1'b0;
        mismatch_count = 0;
        protocol_count = 0;
        timeout_count  = 0;
        test_name      = "reset";
        for (int i = 0; i < 4; i++) begin
            ref_id[i]     = '0;
            exp_frames[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if ({s_tready, m3_tvalid, m2_tvalid, m1_tvalid, m0_tvalid} !== 5'b00000) begin
            protocol_count++;
            $display("s_tready or an output tvalid is not low right after reset");
        end
        check_count(test_name, 0, '0, frame_count_0);
        check_count(test_name, 1, '0, frame_count_1);
        check_count(test_name, 2, '0, frame_count_2);
        check_count(test_name, 3, '0, frame_count_3);

        // nothing written yet, so the frame falls through to port 3
        test_name = "empty_table";
        send_frame(8'h5a, 3, 0);
        drain_outputs();

        test_name = "distinct_ids";
        cfg_write(2'd0, 8'h11);
        cfg_write(2'd1, 8'h22);
        cfg_write(2'd2, 8'h33);
        cfg_write(2'd3, 8'h44);
        send_random_frames(12, 1'b1);
        drain_outputs();

        // entries 1 and 2 now both hold 8'h22, and 8'h33 is gone
        test_name = "default_and_duplicate";
        cfg_write(2'd2, 8'h22);
        send_frame(8'h22, 2, 0);
        send_frame(8'h33, 4, 0);
        send_frame(8'hee, 1, 0);
        send_frame(8'h11, 2, 0);
        drain_outputs();

        test_name = "random_tready";
        @(posedge clk);
        ready_random = 1'b1;
        @(negedge clk);
        send_random_frames(40, 1'b0);

        test_name = "enable_hold";
        send_frame(8'h44, 5, 12);
        send_random_frames(4, 1'b0);
        drain_outputs();

        test_name = "frame_count";
        check_count(test_name, 0, exp_frames[0], frame_count_0);
        check_count(test_name, 1, exp_frames[1], frame_count_1);
        check_count(test_name, 2, exp_frames[2], frame_count_2);
        check_count(test_name, 3, exp_frames[3], frame_count_3);

        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
verilog/axis_route_pkg.sv
verilog/route_select.sv
verilog/port_frame_counter.sv
verilog/axis_demux_64_4.sv
verilog/axis_router_top.sv
testbench/tb_axis_router.sv

/* Makefile */
# Verilator build and run for the stream frame router testbench

VERILATOR ?= verilator
TOP       ?= tb_axis_router
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation PASSED

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q -x -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
